//--- can_ctrl.f
+incdir+source
source/can_pkg.sv
source/can_bit_if.sv
source/can_crc15.sv
source/can_frame_serializer.sv
source/can_bit_stuffer.sv
source/can_bit_destuffer.sv
source/can_frame_deserializer.sv
source/can_ctrl.sv
test/can_ctrl_sva.sv
test/can_ctrl_checker.sv
test/can_ctrl_tb.sv

//--- Bender.yml
package:
  name: can_ctrl

export_include_dirs:
  - source

sources:
  - source/can_pkg.sv
  - source/can_bit_if.sv
  - source/can_crc15.sv
  - source/can_frame_serializer.sv
  - source/can_bit_stuffer.sv
  - source/can_bit_destuffer.sv
  - source/can_frame_deserializer.sv
  - source/can_ctrl.sv
  - target: test
    files:
      - test/can_ctrl_sva.sv
      - test/can_ctrl_checker.sv
      - test/can_ctrl_tb.sv

//--- test/can_ctrl_tb.sv
module can_ctrl_tb
    import can_pkg::*;
();

    localparam int WAIT_LIMIT = 400;   // Longer than any stuffed frame

    logic      clk;
    logic      rst;
    logic      start;
    can_id_t   id;
    can_dlc_t  dlc;
    can_data_t data;
    logic      tx;
    logic      rx;
    logic      busy;
    logic      done;
    can_id_t   rx_id;
    can_dlc_t  rx_dlc;
    can_data_t rx_data;
    logic      rx_valid;
    logic      rx_crc_error;

    logic        expect_error;
    logic        test_end;
    int          exp_frames;
    int          test_num;
    int          timeouts;
    int          errors;
    int          checks;
    logic [31:0] rng;
    logic        flip_en;    // Invert one line bit of the next frame
    int          flip_idx;
    int          bit_cnt;
    int          cur_bit;    // Index of the line bit now on tx

    can_ctrl dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .id           (id),
        .dlc          (dlc),
        .data         (data),
        .tx           (tx),
        .busy         (busy),
        .done         (done),
        .rx           (rx),
        .rx_id        (rx_id),
        .rx_dlc       (rx_dlc),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_crc_error (rx_crc_error)
    );

    can_ctrl_checker chk (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .id           (id),
        .dlc          (dlc),
        .data         (data),
        .tx           (tx),
        .busy         (busy),
        .done         (done),
        .rx_id        (rx_id),
        .rx_dlc       (rx_dlc),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_crc_error (rx_crc_error),
        .expect_error (expect_error),
        .exp_frames   (exp_frames),
        .test_num     (test_num),
        .timeouts     (timeouts),
        .test_end     (test_end),
        .errors       (errors),
        .checks       (checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Loopback line counts line bits from SOF at 0
    always @(posedge clk) begin
        if (busy) begin
            cur_bit <= bit_cnt;
            bit_cnt <= bit_cnt + 1;
        end else begin
            cur_bit <= -1;
            bit_cnt <= 0;
        end
    end

    assign rx = tx ^ (flip_en && cur_bit == flip_idx);

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic request(input can_id_t f_id, input can_dlc_t f_dlc, input can_data_t f_data);
        id    = f_id;
        dlc   = f_dlc;
        data  = f_data;
        start = 1'b1;
        step();
        start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (done !== 1'b1) begin
            $display("Timeout in test %0d: done never came", test_num);
            timeouts++;
        end
    endtask

    task automatic wait_for_rx_pulse();
        int n;
        n = 0;
        while (rx_valid !== 1'b1 && rx_crc_error !== 1'b1 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (rx_valid !== 1'b1 && rx_crc_error !== 1'b1) begin
            $display("Timeout in test %0d: receiver gave no result", test_num);
            timeouts++;
        end
    endtask

    // Skipped once something hung
    task automatic send_frame(input can_id_t f_id, input can_dlc_t f_dlc,
                              input can_data_t f_data);
        if (timeouts == 0) begin
            request(f_id, f_dlc, f_data);
            wait_done();
            wait_for_rx_pulse();
            step();
        end
    endtask

    task automatic end_test(input int frames);
        exp_frames = frames;
        test_end   = 1'b1;
        step();
        test_end   = 1'b0;
        test_num++;
    endtask

    initial begin
        can_id_t   f_id;
        can_dlc_t  f_dlc;
        can_data_t f_data;
        int        i;
        rng          = 32'd42;
        rst          = 1'b1;
        start        = 1'b0;
        id           = '0;
        dlc          = '0;
        data         = '0;
        expect_error = 1'b0;
        test_end     = 1'b0;
        exp_frames   = 0;
        test_num     = 1;
        timeouts     = 0;
        flip_en      = 1'b0;
        flip_idx     = 0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        repeat (20) step();   // Quiet line after reset
        end_test(0);

        for (i = 0; i < 30; i++) begin
            f_id          = can_id_t'(next_rand());
            f_dlc         = can_dlc_t'(next_rand() % 9);
            f_data[31:0]  = next_rand();
            f_data[63:32] = next_rand();
            send_frame(f_id, f_dlc, f_data);
        end
        end_test(30);

        send_frame('0, 4'd8, '0);   // Worst case stuffing
        send_frame('0, 4'd8, '1);
        end_test(2);

        for (i = 9; i < 16; i++) begin
            f_data[31:0]  = next_rand();
            f_data[63:32] = next_rand();
            send_frame(can_id_t'(next_rand()), can_dlc_t'(i), f_data);
        end
        end_test(7);

        // Alternating id and data leave no stuff bits before line bit 30 in data byte 1
        expect_error = 1'b1;
        flip_idx     = 30;
        flip_en      = 1'b1;
        send_frame(11'h555, 4'd8, {8{8'h55}});
        flip_en      = 1'b0;
        expect_error = 1'b0;
        end_test(1);

        request(11'h123, 4'd8, 64'h0123_4567_89ab_cdef);
        repeat (5) step();
        request(11'h7ff, 4'd2, 64'hffff_0000_ffff_0000);   // Lands while busy
        wait_done();
        wait_for_rx_pulse();
        repeat (40) step();
        end_test(1);

        $display("%0d tests, %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
                 test_num - 1, checks, errors, timeouts, dut.u_sva.fail_count);
        if (errors == 0 && timeouts == 0 && dut.u_sva.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- test/can_ctrl_checker.sv
`include "can_defs.svh"

module can_ctrl_checker
    import can_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  can_id_t   id,
    input  can_dlc_t  dlc,
    input  can_data_t data,
    input  logic      tx,
    input  logic      busy,
    input  logic      done,
    input  can_id_t   rx_id,
    input  can_dlc_t  rx_dlc,
    input  can_data_t rx_data,
    input  logic      rx_valid,
    input  logic      rx_crc_error,
    input  logic      expect_error,  // Line fault on the current frame
    input  int        exp_frames,
    input  int        test_num,
    input  int        timeouts,
    input  logic      test_end,
    output int        errors,
    output int        checks
);

    can_id_t   exp_id;
    can_dlc_t  exp_dlc;
    can_data_t exp_data;
    int        exp_len;
    int        busy_cnt;
    int        accepted;
    int        err_base;
    int        to_base;
    logic      tx_pending;   // Accepted and not yet done
    logic      rx_pending;   // Still waiting for a receive pulse

    function automatic int nbytes_of(input can_dlc_t f_dlc);
        return (f_dlc > `CAN_MAX_BYTES) ? `CAN_MAX_BYTES : int'(f_dlc);
    endfunction

    // Unstuffed line bits from SOF through data with SOF at bit 0
    function automatic logic [127:0] head_bits(input can_id_t f_id, input can_dlc_t f_dlc,
                                               input can_data_t f_data);
        logic [127:0] b;
        int           k;
        b = '0;   // SOF, RTR, IDE and r0 stay dominant
        for (k = 0; k < 11; k++) begin
            b[1 + k] = f_id[10 - k];
        end
        for (k = 0; k < 4; k++) begin
            b[15 + k] = f_dlc[3 - k];
        end
        for (k = 0; k < 8 * nbytes_of(f_dlc); k++) begin
            b[19 + k] = f_data[8 * (k / 8) + 7 - k % 8];   // Byte 0 first and each byte MSB first
        end
        return b;
    endfunction

    // CRC-15 over the first n line bits from a zero start value
    function automatic can_crc_t crc15_ref(input logic [127:0] b, input int n);
        can_crc_t c;
        logic     top;
        int       k;
        c = '0;
        for (k = 0; k < n; k++) begin
            top = b[k] ^ c[14];
            c = {c[13:0], 1'b0};
            if (top) begin
                c = c ^ `CAN_CRC_POLY;
            end
        end
        return c;
    endfunction

    // Busy cycles including stuff bits and tail
    function automatic int line_len(input can_id_t f_id, input can_dlc_t f_dlc,
                                    input can_data_t f_data);
        logic [127:0] b;
        can_crc_t     c;
        logic         last;
        int           n;
        int           k;
        int           run;
        int           len;
        b = head_bits(f_id, f_dlc, f_data);
        n = 19 + 8 * nbytes_of(f_dlc);
        c = crc15_ref(b, n);
        for (k = 0; k < 15; k++) begin
            b[n + k] = c[14 - k];
        end
        n = n + 15;
        last = b[0];
        run = 1;
        len = 1;
        for (k = 1; k < n; k++) begin
            if (run == 5) begin   // Stuff bit of opposite value
                last = ~last;
                run = 1;
                len++;
            end
            if (b[k] == last) begin
                run++;
            end else begin
                last = b[k];
                run = 1;
            end
            len++;
        end
        return len + 10;
    endfunction

    // Bytes past the capped DLC read back as zero
    function automatic can_data_t exp_data_of(input can_dlc_t f_dlc, input can_data_t f_data);
        can_data_t keep;
        int        k;
        keep = '0;
        for (k = 0; k < nbytes_of(f_dlc); k++) begin
            keep[8 * k +: 8] = 8'hff;
        end
        return f_data & keep;
    endfunction

    task automatic fail(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic check(input logic ok, input string msg);
        checks++;
        if (!ok) begin
            fail(msg);
        end
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        accepted = 0;
        err_base = 0;
        to_base  = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            tx_pending = 1'b0;
            rx_pending = 1'b0;
        end else begin
            if (!busy && tx !== 1'b1) begin
                fail("tx dominant outside a frame");
            end
            if (busy) begin
                if (!tx_pending) begin
                    fail("busy without an accepted start");
                end
                busy_cnt++;
            end
            if (done) begin
                if (!tx_pending) begin
                    fail("done without an accepted start");
                end
                check(busy_cnt == exp_len,
                      $sformatf("busy for %0d cycles, expected %0d", busy_cnt, exp_len));
                tx_pending = 1'b0;
            end
            if (rx_valid || rx_crc_error) begin
                if (!rx_pending) begin
                    fail("receive pulse with no frame sent");
                end
                rx_pending = 1'b0;
                check(rx_crc_error === expect_error,
                      $sformatf("rx_crc_error %b, expected %b", rx_crc_error, expect_error));
                if (rx_valid) begin
                    check(rx_id === exp_id,
                          $sformatf("rx_id %h, expected %h", rx_id, exp_id));
                    check(rx_dlc === exp_dlc,
                          $sformatf("rx_dlc %0d, expected %0d", rx_dlc, exp_dlc));
                    check(rx_data === exp_data,
                          $sformatf("rx_data %h, expected %h", rx_data, exp_data));
                end
            end
            if (start && !tx_pending) begin
                exp_id     = id;
                exp_dlc    = dlc;
                exp_data   = exp_data_of(dlc, data);
                exp_len    = line_len(id, dlc, data);
                busy_cnt   = 0;
                tx_pending = 1'b1;
                rx_pending = 1'b1;
                accepted++;
            end
            if (test_end) begin
                check(accepted == exp_frames,
                      $sformatf("%0d frames accepted, expected %0d", accepted, exp_frames));
                check(!tx_pending && !rx_pending, "frame still in flight at end of test");
                $display("test %0d finished with %0d errors", test_num,
                         errors - err_base + timeouts - to_base);
                accepted = 0;
                err_base = errors;
                to_base  = timeouts;
            end
        end
    end

endmodule

//--- test/can_ctrl_sva.sv
module can_ctrl_sva (
    input logic clk,
    input logic rst,
    input logic tx,
    input logic busy,
    input logic done,
    input logic rx_valid,
    input logic rx_crc_error
);

    int fail_count = 0;   // Failed assertions so far

    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // busy falls on the same edge that raises done
    done_not_busy: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else begin
            $error("busy still high while done is high");
            fail_count++;
        end

    rx_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(rx_valid && rx_crc_error))
        else begin
            $error("rx_valid and rx_crc_error high together");
            fail_count++;
        end

    idle_recessive: assert property (@(posedge clk) disable iff (rst) !busy |-> tx)
        else begin
            $error("tx dominant while not busy");
            fail_count++;
        end

endmodule

bind can_ctrl can_ctrl_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .tx           (tx),
    .busy         (busy),
    .done         (done),
    .rx_valid     (rx_valid),
    .rx_crc_error (rx_crc_error)
);

//--- source/can_ctrl.sv
module can_ctrl
    import can_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Transmit request
    input  logic      start,
    input  can_id_t   id,
    input  can_dlc_t  dlc,
    input  can_data_t data,
    output logic      tx,
    output logic      busy,
    output logic      done,
    // Receive
    input  logic      rx,
    output can_id_t   rx_id,
    output can_dlc_t  rx_dlc,
    output can_data_t rx_data,
    output logic      rx_valid,
    output logic      rx_crc_error
);

    can_bit_if tx_bs ();
    can_bit_if rx_bs ();

    can_frame_serializer u_ser (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .id    (id),
        .dlc   (dlc),
        .data  (data),
        .busy  (busy),
        .done  (done),
        .bs    (tx_bs.ser)
    );

    can_bit_stuffer u_stuf (
        .clk (clk),
        .rst (rst),
        .bs  (tx_bs.stuf),
        .tx  (tx)
    );

    can_bit_destuffer u_destuf (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .bs  (rx_bs.destuf)
    );

    can_frame_deserializer u_deser (
        .clk          (clk),
        .rst          (rst),
        .bs           (rx_bs.deser),
        .rx_id        (rx_id),
        .rx_dlc       (rx_dlc),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_crc_error (rx_crc_error)
    );

endmodule

//--- source/can_frame_deserializer.sv
`include "can_defs.svh"

module can_frame_deserializer
    import can_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    can_bit_if.deser  bs,
    output can_id_t   rx_id,
    output can_dlc_t  rx_dlc,
    output can_data_t rx_data,
    output logic      rx_valid,
    output logic      rx_crc_error
);

    rx_state_e  state;
    logic [6:0] cnt;
    logic [6:0] last_cnt;
    can_dlc_t   dlc_next;
    can_dlc_t   nbytes;
    can_crc_t   crc;       // Computed
    can_crc_t   crc_rx;    // Received
    logic       crc_en;

    assign bs.stuff_en = state inside {RX_ID, RX_CTRL, RX_DLC, RX_DATA, RX_CRC};

    // SOF is skipped, a zero bit leaves a cleared CRC at zero
    assign crc_en = bs.bit_en && (state inside {RX_ID, RX_CTRL, RX_DLC, RX_DATA});

    assign dlc_next = {rx_dlc[`CAN_DLC_W-2:0], bs.bit_val};
    assign nbytes   = (rx_dlc > `CAN_MAX_BYTES) ? can_dlc_t'(`CAN_MAX_BYTES) : rx_dlc;

    always_comb begin
        case (state)
            RX_ID:   last_cnt = 7'(`CAN_ID_W - 1);
            RX_CTRL: last_cnt = 7'd2;
            RX_DLC:  last_cnt = 7'(`CAN_DLC_W - 1);
            RX_DATA: last_cnt = {nbytes, 3'b000} - 7'd1;
            RX_CRC:  last_cnt = 7'(`CAN_CRC_W - 1);
            RX_TAIL: last_cnt = 7'(`CAN_TAIL_BITS - 1);
            default: last_cnt = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= RX_IDLE;
            cnt          <= '0;
            rx_valid     <= 1'b0;
            rx_crc_error <= 1'b0;
        end else begin
            rx_valid     <= 1'b0;
            rx_crc_error <= 1'b0;
            if (bs.bit_en) begin
                if (state == RX_IDLE) begin
                    if (!bs.bit_val) begin   // SOF
                        state <= RX_ID;
                        cnt   <= '0;
                    end
                end else if (cnt == last_cnt) begin
                    cnt <= '0;
                    case (state)
                        RX_ID:   state <= RX_CTRL;
                        RX_CTRL: state <= RX_DLC;
                        RX_DLC:  state <= (dlc_next == '0) ? RX_CRC : RX_DATA;
                        RX_DATA: state <= RX_CRC;
                        RX_CRC:  state <= RX_TAIL;
                        default: begin
                            state        <= RX_IDLE;
                            rx_valid     <= (crc == crc_rx);
                            rx_crc_error <= (crc != crc_rx);
                        end
                    endcase
                end else begin
                    cnt <= cnt + 7'd1;
                end
            end
        end
    end

    // Field assembly, RTR/IDE/r0 and tail bits are dropped
    always_ff @(posedge clk) begin
        if (bs.bit_en) begin
            case (state)
                RX_IDLE: begin
                    if (!bs.bit_val) begin
                        rx_data <= '0;       // Bytes past DLC stay zero
                    end
                end
                RX_ID:   rx_id   <= {rx_id[`CAN_ID_W-2:0], bs.bit_val};
                RX_DLC:  rx_dlc  <= dlc_next;
                RX_DATA: rx_data[{cnt[5:3], ~cnt[2:0]}] <= bs.bit_val;
                RX_CRC:  crc_rx  <= {crc_rx[`CAN_CRC_W-2:0], bs.bit_val};
                default: begin
                end
            endcase
        end
    end

    can_crc15 u_crc (
        .clk    (clk),
        .rst    (rst),
        .clear  (state == RX_IDLE),
        .en     (crc_en),
        .bit_in (bs.bit_val),
        .crc    (crc)
    );

endmodule

//--- source/can_bit_destuffer.sv
`include "can_defs.svh"

module can_bit_destuffer
    import can_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx,
    can_bit_if.destuf bs
);

    logic     rx_q;   // Sample on offer
    logic     prev;   // Sample before it
    can_run_t run;    // Equal samples ending at prev

    assign bs.bit_val = rx_q;

    // Five equal samples before this one, so it is a stuff bit
    assign bs.bit_en = !(bs.stuff_en && (run == `CAN_STUFF_LIMIT));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_q <= 1'b1;
            prev <= 1'b1;
            run  <= can_run_t'(`CAN_STUFF_LIMIT);
        end else begin
            rx_q <= rx;
            prev <= rx_q;
            if (rx_q != prev) begin
                run <= can_run_t'(1);
            end else if (run != `CAN_STUFF_LIMIT) begin
                run <= run + 1'b1;  // Saturates on an idle line
            end
        end
    end

endmodule

//--- source/can_bit_stuffer.sv
`include "can_defs.svh"

module can_bit_stuffer
    import can_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    can_bit_if.stuf bs,
    output logic    tx
);

    can_run_t run;       // Equal bits on tx, ending with the current one
    logic     stuff;
    logic     line_bit;

    assign stuff     = bs.stuff_en && (run == `CAN_STUFF_LIMIT);
    assign bs.bit_en = !stuff;  // Framer holds its bit over a stuff cycle

    always_comb begin
        if (stuff) begin
            line_bit = ~tx;
        end else if (bs.frame_start || bs.stuff_en) begin
            line_bit = bs.bit_val;
        end else begin
            line_bit = 1'b1;    // Tail and idle
        end
    end

    // Run is tracked even while idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx  <= 1'b1;
            run <= can_run_t'(`CAN_STUFF_LIMIT);
        end else begin
            tx <= line_bit;
            if (line_bit != tx) begin
                run <= can_run_t'(1);
            end else if (run != `CAN_STUFF_LIMIT) begin
                run <= run + 1'b1;
            end
        end
    end

endmodule

//--- source/can_frame_serializer.sv
`include "can_defs.svh"

module can_frame_serializer
    import can_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  can_id_t   id,
    input  can_dlc_t  dlc,
    input  can_data_t data,
    output logic      busy,
    output logic      done,
    can_bit_if.ser    bs
);

    tx_field_e  field;
    logic [6:0] cnt;       // Bit index inside current field
    logic [6:0] last_cnt;
    can_id_t    id_q;
    can_dlc_t   dlc_q;
    can_data_t  data_q;
    can_dlc_t   nbytes;
    can_crc_t   crc;
    logic       accept;
    logic       crc_en;

    assign busy   = (field != TX_IDLE);
    assign accept = start && !busy;  // Start during a frame is dropped
    assign nbytes = (dlc_q > `CAN_MAX_BYTES) ? can_dlc_t'(`CAN_MAX_BYTES) : dlc_q;

    assign bs.frame_start = (field == TX_SOF);
    assign bs.stuff_en    = field inside {TX_ID, TX_CTRL, TX_DLC, TX_DATA, TX_CRC};
    assign crc_en = bs.bit_en && (field inside {TX_SOF, TX_ID, TX_CTRL, TX_DLC, TX_DATA});

    always_comb begin
        case (field)
            TX_ID:   last_cnt = 7'(`CAN_ID_W - 1);
            TX_CTRL: last_cnt = 7'd2;              // RTR, IDE, r0
            TX_DLC:  last_cnt = 7'(`CAN_DLC_W - 1);
            TX_DATA: last_cnt = {nbytes, 3'b000} - 7'd1;
            TX_CRC:  last_cnt = 7'(`CAN_CRC_W - 1);
            TX_TAIL: last_cnt = 7'(`CAN_TAIL_BITS - 1);
            default: last_cnt = '0;                // SOF is a single bit
        endcase
    end

    // Byte 0 goes first, every byte MSB first
    always_comb begin
        case (field)
            TX_SOF:  bs.bit_val = 1'b0;
            TX_ID:   bs.bit_val = id_q[`CAN_ID_W - 1 - cnt];
            TX_CTRL: bs.bit_val = 1'b0;
            TX_DLC:  bs.bit_val = dlc_q[`CAN_DLC_W - 1 - cnt];
            TX_DATA: bs.bit_val = data_q[{cnt[5:3], ~cnt[2:0]}];
            TX_CRC:  bs.bit_val = crc[`CAN_CRC_W - 1 - cnt];
            default: bs.bit_val = 1'b1;            // Tail and idle are recessive
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            field <= TX_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                field <= TX_SOF;
                cnt   <= '0;
            end else if (busy && bs.bit_en) begin
                if (cnt == last_cnt) begin
                    cnt <= '0;
                    case (field)
                        TX_SOF:  field <= TX_ID;
                        TX_ID:   field <= TX_CTRL;
                        TX_CTRL: field <= TX_DLC;
                        TX_DLC:  field <= (nbytes == '0) ? TX_CRC : TX_DATA;
                        TX_DATA: field <= TX_CRC;
                        TX_CRC:  field <= TX_TAIL;
                        default: begin
                            field <= TX_IDLE;
                            done  <= 1'b1;
                        end
                    endcase
                end else begin
                    cnt <= cnt + 7'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_q   <= id;
            dlc_q  <= dlc;
            data_q <= data;
        end
    end

    can_crc15 u_crc (
        .clk    (clk),
        .rst    (rst),
        .clear  (accept),
        .en     (crc_en),
        .bit_in (bs.bit_val),
        .crc    (crc)
    );

endmodule

//--- source/can_crc15.sv
`include "can_defs.svh"

module can_crc15
    import can_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  logic     en,
    input  logic     bit_in,
    output can_crc_t crc
);

    logic feedback;

    assign feedback = bit_in ^ crc[`CAN_CRC_W-1];

    // Shift left, fold polynomial in when the outgoing bit differs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            crc <= {crc[`CAN_CRC_W-2:0], 1'b0} ^ (feedback ? `CAN_CRC_POLY : '0);
        end
    end

endmodule

//--- source/can_bit_if.sv
interface can_bit_if;

    logic bit_val;      // Frame bit, unstuffed
    logic bit_en;       // Bit moves this cycle
    logic stuff_en;     // Bit lies between ID and last CRC bit
    logic frame_start;  // SOF

    // Transmit side
    modport ser (
        output bit_val,
        output stuff_en,
        output frame_start,
        input  bit_en
    );

    modport stuf (
        input  bit_val,
        input  stuff_en,
        input  frame_start,
        output bit_en
    );

    // Receive side, frame_start not used here
    modport destuf (
        output bit_val,
        output bit_en,
        input  stuff_en
    );

    modport deser (
        input  bit_val,
        input  bit_en,
        output stuff_en
    );

endinterface

//--- source/can_pkg.sv
`include "can_defs.svh"

package can_pkg;

    typedef logic [`CAN_ID_W-1:0]   can_id_t;
    typedef logic [`CAN_DLC_W-1:0]  can_dlc_t;
    typedef logic [`CAN_DATA_W-1:0] can_data_t;
    typedef logic [`CAN_CRC_W-1:0]  can_crc_t;

    // Run length of equal line bits, saturates at the stuff limit
    typedef logic [$clog2(`CAN_STUFF_LIMIT + 1)-1:0] can_run_t;

    // Transmit fields in line order
    typedef enum logic [2:0] {
        TX_IDLE, TX_SOF, TX_ID, TX_CTRL, TX_DLC, TX_DATA, TX_CRC, TX_TAIL
    } tx_field_e;

    // SOF is taken in RX_IDLE
    typedef enum logic [2:0] {
        RX_IDLE, RX_ID, RX_CTRL, RX_DLC, RX_DATA, RX_CRC, RX_TAIL
    } rx_state_e;

endpackage

//--- source/can_defs.svh
`ifndef CAN_DEFS_SVH
`define CAN_DEFS_SVH

// Frame field widths
`define CAN_ID_W        11
`define CAN_DLC_W       4
`define CAN_DATA_W      64
`define CAN_CRC_W       15

// CRC-15 generator, x^15 term implied
`define CAN_CRC_POLY    15'h4599

// Equal line bits before a stuff bit goes in
`define CAN_STUFF_LIMIT 5

`define CAN_MAX_BYTES   8   // DLC 9..15 still carry 8 bytes

// CRC delimiter, ACK slot, ACK delimiter, 7 EOF
`define CAN_TAIL_BITS   10

`endif
